// File: Bender.yml
package:
  name: kvdb

export_include_dirs:
  - logic

sources:
  - files:
      - logic/kvdb_pkg.sv
      - logic/kvdb_reg_if.sv
      - logic/kvdb_cmd_if.sv
      - logic/kvdb_wb_regs.sv
      - logic/kvdb_ctrl.sv
      - logic/kvdb_stash.sv
      - logic/kvdb_top.sv
  - target: test
    files:
      - bench/kvdb_asserts.sv
      - bench/kvdb_tb.sv

// File: bench/kvdb_asserts.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

module kvdb_asserts (
    input logic                        clk,
    input logic                        srst,
    input logic                        wb_cyc,
    input logic                        wb_stb,
    input logic                        wb_ack,
    input logic                        req,
    input logic                        rdy,
    input logic                        ack,
    input kvdb_pkg::command_t          command,
    input logic [`KVDB_KEY_BITS-1:0]   key,
    input logic [`KVDB_VALUE_BITS-1:0] set_value
);

    logic in_flight;

    // Open request between acceptance and the stash ack
    always_ff @(posedge clk) begin
        if (srst) begin
            in_flight <= 1'b0;
        end else if (req && rdy) begin
            in_flight <= 1'b1;
        end else if (ack) begin
            in_flight <= 1'b0;
        end
    end

    // ------------------------------
    // Wishbone
    // ------------------------------
    wb_ack_in_cycle : assert property (@(posedge clk) disable iff (srst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside an active bus cycle");

    wb_ack_single : assert property (@(posedge clk) disable iff (srst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    // ------------------------------
    // Command handshake
    // ------------------------------
    req_held : assert property (@(posedge clk) disable iff (srst)
        (req && !rdy) |=> (req && $stable(command) && $stable(key) && $stable(set_value)))
        else $error("request dropped or changed before rdy");

    ack_in_flight : assert property (@(posedge clk) disable iff (srst)
        ack |-> in_flight)
        else $error("stash ack with no request in flight");

endmodule

bind kvdb_top kvdb_asserts u_asserts (
    .clk       ( clk ),
    .srst      ( srst ),
    .wb_cyc    ( wb_cyc ),
    .wb_stb    ( wb_stb ),
    .wb_ack    ( wb_ack ),
    .req       ( cmd_if.req ),
    .rdy       ( cmd_if.rdy ),
    .ack       ( cmd_if.ack ),
    .command   ( cmd_if.command ),
    .key       ( cmd_if.key ),
    .set_value ( cmd_if.set_value )
);

// File: bench/kvdb_tb.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

module kvdb_tb;
    import kvdb_pkg::*;

    localparam int N_RANDOM   = 200;
    localparam int MAX_CYCLES = N_RANDOM * 40 + 500;
    localparam int ACK_LIMIT  = 8;

    logic                        clk;
    logic                        srst;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [`KVDB_ADR_BITS-1:0]   wb_adr;
    logic [31:0]                 wb_dat_w;
    logic [31:0]                 wb_dat_r;
    logic                        wb_ack;

    // Reference store indexed by key
    logic [`KVDB_VALUE_BITS-1:0] ref_store [logic [`KVDB_KEY_BITS-1:0]];

    int errors;
    int checks;
    int cycles;
    int rnd_seed;

    // Last command as read back, and what the model expects
    logic [31:0] act_status;
    logic [31:0] act_value;
    logic [31:0] act_valid;
    logic        exp_valid;
    logic [31:0] exp_value;
    logic        exp_error;
    logic        exp_chk_valid;
    logic        exp_chk_value;
    int          exp_fill;
    event        result_ev;

    kvdb_top dut0 (
        .clk      ( clk ),
        .srst     ( srst ),
        .wb_cyc   ( wb_cyc ),
        .wb_stb   ( wb_stb ),
        .wb_we    ( wb_we ),
        .wb_adr   ( wb_adr ),
        .wb_dat_w ( wb_dat_w ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_code(input status_code_t got, input status_code_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s flag is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // Wishbone master
    // ------------------------------
    task automatic bus_cycle(input reg_addr_t adr, input logic we, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && (waited < ACK_LIMIT));
        if (!wb_ack) begin
            errors++;
            $display("Bus error: no ack for the access to address %0d", adr);
        end
        rdata = wb_dat_r;
        // Held through the ack cycle so the write lands
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(adr, 1'b1, data, unused);
    endtask

    task automatic wb_read(input reg_addr_t adr, output logic [31:0] data);
        bus_cycle(adr, 1'b0, 32'd0, data);
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic void ref_apply(input command_t cmd, input logic [7:0] key,
                                      input logic [31:0] value, output logic e_valid,
                                      output logic [31:0] e_value, output logic e_error,
                                      output logic c_valid, output logic c_value);
        logic present;
        present = ref_store.exists(key);
        e_valid = present;
        e_value = '0;
        if (present) begin
            e_value = ref_store[key];
        end
        e_error = 1'b0;
        c_valid = 1'b0;
        c_value = 1'b0;
        case (cmd)
            CMD_GET : begin
                c_valid = 1'b1;
                c_value = 1'b1;
            end
            CMD_SET : begin
                if (!present && (ref_store.num() >= `KVDB_DEPTH)) begin
                    e_error = 1'b1;
                end else begin
                    ref_store[key] = value;
                end
            end
            CMD_UNSET : begin
                c_valid = 1'b1;
                c_value = !present;
                if (present) begin
                    ref_store.delete(key);
                end
            end
            default : ref_store.delete();
        endcase
    endfunction

    // One transaction from register writes to result reads
    task automatic run_cmd(input command_t cmd, input logic [7:0] key, input logic [31:0] value);
        logic [31:0] status_w;
        wb_write(REG_KEY, 32'(key));
        wb_write(REG_SET_VALUE, value);
        wb_write(REG_COMMAND, 32'(cmd));
        status_w = '0;
        // Flags alone end the poll so the code stays a real check
        while (!(status_w[4] || status_w[5])) begin
            wb_read(REG_STATUS, status_w);
        end
        act_status = status_w;
        wb_read(REG_GET_VALUE, act_value);
        wb_read(REG_GET_VALID, act_valid);
        ref_apply(cmd, key, value, exp_valid, exp_value, exp_error, exp_chk_valid, exp_chk_value);
        exp_fill = ref_store.num();
        -> result_ev;
    endtask

    // Compares every completed command against the model
    initial begin
        forever begin
            @(result_ev);
            check_code(status_code_t'(act_status[1:0]), STATUS_READY, "status code");
            check_flag(act_status[4], !exp_error, "done");
            check_flag(act_status[5], exp_error, "error");
            check_value(32'(act_status[11:8]), 32'(exp_fill), "fill count");
            if (exp_chk_valid) begin
                check_valid(act_valid[0], exp_valid, "get_valid");
            end
            if (exp_chk_value) begin
                check_value(act_value, exp_value, "get_value");
            end
        end
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [31:0] rd;
        command_t    cmd;
        logic [7:0]  key;
        int          r;
        errors   = 0;
        checks   = 0;
        rnd_seed = $urandom(38);
        srst     = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(negedge clk);
        srst = 1'b0;

        // Init walk, then ready and empty
        wb_read(REG_STATUS, rd);
        check_code(status_code_t'(rd[1:0]), STATUS_INIT, "status after reset");
        while (rd[1:0] == STATUS_INIT) begin
            wb_read(REG_STATUS, rd);
        end
        check_code(status_code_t'(rd[1:0]), STATUS_READY, "status after init");
        check_value(32'(rd[11:8]), 32'd0, "fill after init");
        wb_read(REG_INFO, rd);
        check_value(rd, {8'd0, 8'd8, 8'd32, 8'd8}, "INFO word");

        // Set, get and overwrite
        run_cmd(CMD_SET, 8'h21, 32'hcafe_0001);
        run_cmd(CMD_GET, 8'h21, 32'd0);
        run_cmd(CMD_SET, 8'h21, 32'h1234_5678);
        run_cmd(CMD_GET, 8'h21, 32'd0);

        // Absent keys, then removal of a present one
        run_cmd(CMD_GET, 8'h55, 32'd0);
        run_cmd(CMD_UNSET, 8'h55, 32'd0);
        run_cmd(CMD_UNSET, 8'h21, 32'd0);

        // Full stash refuses a new key
        for (int i = 0; i < 8; i++) begin
            run_cmd(CMD_SET, 8'h40 + 8'(i), 32'h0a00_0000 + 32'(i));
        end
        run_cmd(CMD_SET, 8'h60, 32'hdead_beef);
        wb_read(REG_STATUS, rd);
        check_flag(rd[5], 1'b0, "error after status read");
        check_flag(rd[4], 1'b0, "done after status read");
        check_value(32'(rd[11:8]), 32'(ref_store.num()), "fill when full");

        // Clear empties everything
        run_cmd(CMD_CLEAR, 8'h00, 32'd0);
        for (int i = 0; i < 8; i++) begin
            run_cmd(CMD_GET, 8'h40 + 8'(i), 32'd0);
        end

        // Random mix over 12 keys
        for (int n = 0; n < N_RANDOM; n++) begin
            r   = $urandom_range(0, 15);
            key = 8'h10 + 8'($urandom_range(0, 11));
            if (r == 0) begin
                cmd = CMD_CLEAR;
            end else if (r < 6) begin
                cmd = CMD_GET;
            end else if (r < 12) begin
                cmd = CMD_SET;
            end else begin
                cmd = CMD_UNSET;
            end
            run_cmd(cmd, key, $urandom);
        end

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/kvdb_cmd_if.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

interface kvdb_cmd_if;
    import kvdb_pkg::*;

    // Request, held until accepted
    logic                          req;
    command_t                      command;
    logic [`KVDB_KEY_BITS-1:0]     key;
    logic [`KVDB_VALUE_BITS-1:0]   set_value;

    // Response side, results valid with ack
    logic                          rdy;
    logic                          ack;
    db_status_t                    status;
    logic                          get_valid;
    logic [`KVDB_VALUE_BITS-1:0]   get_value;
    logic [`KVDB_FILL_BITS-1:0]    fill;
    logic                          init_done;

    modport ctrl (
        output req, command, key, set_value,
        input  rdy, ack, status, get_valid, get_value, fill, init_done
    );

    modport stash (
        input  req, command, key, set_value,
        output rdy, ack, status, get_valid, get_value, fill, init_done
    );

endinterface

// File: logic/kvdb_ctrl.sv
`timescale 1ns/1ns

module kvdb_ctrl (
    input  logic      clk,
    input  logic      srst,
    kvdb_reg_if.ctrl  reg_if,
    kvdb_cmd_if.ctrl  cmd_if
);
    import kvdb_pkg::*;

    typedef enum logic [2:0] {
        ST_INIT  = 3'd0,
        ST_IDLE  = 3'd1,
        ST_REQ   = 3'd2,
        ST_BUSY  = 3'd3,
        ST_DONE  = 3'd4,
        ST_ERROR = 3'd5
    } state_t;

    state_t state;
    state_t nxt_state;
    logic   cmd_accept;

    // Only a command written while READY starts a transaction
    assign cmd_accept = reg_if.cmd_wr && (state == ST_IDLE)
                        && (reg_if.status_code == STATUS_READY);

    // ------------------------------
    // Command latch
    // ------------------------------
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd_if.command   <= reg_if.cmd_code;
            cmd_if.key       <= reg_if.key;
            cmd_if.set_value <= reg_if.set_value;
        end
    end

    // ------------------------------
    // Transaction FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_INIT;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            ST_INIT : if (cmd_if.init_done) nxt_state = ST_IDLE;
            ST_IDLE : if (cmd_accept) nxt_state = ST_REQ;
            ST_REQ  : if (cmd_if.rdy) nxt_state = ST_BUSY;
            ST_BUSY : begin
                if (cmd_if.ack) begin
                    nxt_state = (cmd_if.status == DB_ERROR) ? ST_ERROR : ST_DONE;
                end
            end
            default : nxt_state = ST_IDLE;
        endcase
    end

    assign cmd_if.req = (state == ST_REQ);

    // ------------------------------
    // Status and results
    // ------------------------------
    // Code lags the FSM by one cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            reg_if.status_code <= STATUS_INIT;
        end else begin
            case (state)
                ST_INIT         : reg_if.status_code <= STATUS_INIT;
                ST_REQ, ST_BUSY : reg_if.status_code <= STATUS_BUSY;
                default         : reg_if.status_code <= STATUS_READY;
            endcase
        end
    end

    // Sticky flags, setting wins over any clear
    always_ff @(posedge clk) begin
        if (srst) begin
            reg_if.done  <= 1'b0;
            reg_if.error <= 1'b0;
        end else begin
            if (state == ST_DONE) begin
                reg_if.done <= 1'b1;
            end else if (cmd_accept || reg_if.status_rd) begin
                reg_if.done <= 1'b0;
            end
            if (state == ST_ERROR) begin
                reg_if.error <= 1'b1;
            end else if (cmd_accept || reg_if.status_rd) begin
                reg_if.error <= 1'b0;
            end
        end
    end

    // Captured on the stash ack
    always_ff @(posedge clk) begin
        if (srst) begin
            reg_if.get_valid <= 1'b0;
            reg_if.get_value <= '0;
        end else if ((state == ST_BUSY) && cmd_if.ack) begin
            reg_if.get_valid <= cmd_if.get_valid;
            reg_if.get_value <= cmd_if.get_value;
        end
    end

    assign reg_if.fill = cmd_if.fill;

endmodule

// File: logic/kvdb_pkg.sv
`include "kvdb_settings.svh"

package kvdb_pkg;

    // Database operation
    typedef enum logic [2:0] {
        CMD_NOP   = 3'd0,
        CMD_GET   = 3'd1,
        CMD_SET   = 3'd2,
        CMD_UNSET = 3'd3,
        CMD_CLEAR = 3'd4
    } command_t;

    // Sequencer condition as seen in STATUS
    typedef enum logic [1:0] {
        STATUS_INIT  = 2'd0,
        STATUS_READY = 2'd1,
        STATUS_BUSY  = 2'd2
    } status_code_t;

    // Stash result
    typedef enum logic {
        DB_OK    = 1'b0,
        DB_ERROR = 1'b1
    } db_status_t;

    // Word address map
    typedef enum logic [`KVDB_ADR_BITS-1:0] {
        REG_INFO      = 3'd0,
        REG_COMMAND   = 3'd1,
        REG_KEY       = 3'd2,
        REG_SET_VALUE = 3'd3,
        REG_STATUS    = 3'd4,
        REG_GET_VALUE = 3'd5,
        REG_GET_VALID = 3'd6
    } reg_addr_t;

endpackage

// File: logic/kvdb_reg_if.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

interface kvdb_reg_if;
    import kvdb_pkg::*;

    // Register block to sequencer
    logic                          cmd_wr;
    command_t                      cmd_code;
    logic [`KVDB_KEY_BITS-1:0]     key;
    logic [`KVDB_VALUE_BITS-1:0]   set_value;
    logic                          status_rd;

    // Sequencer to register block
    status_code_t                  status_code;
    logic                          done;
    logic                          error;
    logic [`KVDB_FILL_BITS-1:0]    fill;
    logic [`KVDB_VALUE_BITS-1:0]   get_value;
    logic                          get_valid;

    modport regs (
        output cmd_wr, cmd_code, key, set_value, status_rd,
        input  status_code, done, error, fill, get_value, get_valid
    );

    modport ctrl (
        input  cmd_wr, cmd_code, key, set_value, status_rd,
        output status_code, done, error, fill, get_value, get_valid
    );

endinterface

// File: logic/kvdb_settings.svh
`ifndef KVDB_SETTINGS_SVH
`define KVDB_SETTINGS_SVH

// ------------------------------
// Data widths
// ------------------------------
`define KVDB_KEY_BITS 8
`define KVDB_VALUE_BITS 32

// ------------------------------
// Stash geometry
// ------------------------------
`define KVDB_DEPTH 8
// Counts 0 to KVDB_DEPTH inclusive
`define KVDB_FILL_BITS $clog2(`KVDB_DEPTH + 1)

// Wishbone word address
`define KVDB_ADR_BITS 3

`endif

// File: logic/kvdb_stash.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

module kvdb_stash (
    input  logic       clk,
    input  logic       srst,
    kvdb_cmd_if.stash  cmd_if
);
    import kvdb_pkg::*;

    localparam int DEPTH      = `KVDB_DEPTH;
    localparam int KEY_BITS   = `KVDB_KEY_BITS;
    localparam int VALUE_BITS = `KVDB_VALUE_BITS;
    localparam int IDX_BITS   = $clog2(DEPTH);

    typedef enum logic [1:0] {
        S_WALK   = 2'd0,
        S_IDLE   = 2'd1,
        S_LOOKUP = 2'd2,
        S_ACK    = 2'd3
    } state_t;

    state_t                state;
    logic [IDX_BITS-1:0]   walk_idx;
    logic                  walk_last;
    logic                  accept;

    command_t              cmd_q;
    logic [KEY_BITS-1:0]   key_q;
    logic [VALUE_BITS-1:0] value_q;

    logic [DEPTH-1:0]      valid;
    logic [KEY_BITS-1:0]   keys   [DEPTH];
    logic [VALUE_BITS-1:0] values [DEPTH];

    logic                  hit;
    logic [IDX_BITS-1:0]   hit_idx;
    logic                  free;
    logic [IDX_BITS-1:0]   free_idx;

    assign cmd_if.rdy = (state == S_IDLE) && cmd_if.init_done;
    assign cmd_if.ack = (state == S_ACK);
    assign accept     = cmd_if.req && cmd_if.rdy;
    assign walk_last  = (walk_idx == IDX_BITS'(DEPTH - 1));

    // ------------------------------
    // Match and free search
    // ------------------------------
    // Downward scan so the lowest index wins
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        free     = 1'b0;
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && (keys[i] == key_q)) begin
                hit     = 1'b1;
                hit_idx = IDX_BITS'(i);
            end
            if (!valid[i]) begin
                free     = 1'b1;
                free_idx = IDX_BITS'(i);
            end
        end
    end

    // ------------------------------
    // Entry storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (state == S_WALK) begin
            valid[walk_idx] <= 1'b0;
        end else if (state == S_LOOKUP) begin
            if (cmd_q == CMD_SET) begin
                if (hit) begin
                    values[hit_idx] <= value_q;
                end else if (free) begin
                    valid[free_idx]  <= 1'b1;
                    keys[free_idx]   <= key_q;
                    values[free_idx] <= value_q;
                end
            end else if ((cmd_q == CMD_UNSET) && hit) begin
                valid[hit_idx] <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Control
    // ------------------------------
    // Reset enters the same walk that CLEAR uses
    always_ff @(posedge clk) begin
        if (srst) begin
            state            <= S_WALK;
            walk_idx         <= '0;
            cmd_if.init_done <= 1'b0;
            cmd_if.fill      <= '0;
        end else begin
            case (state)
                S_WALK : begin
                    walk_idx <= walk_idx + 1'b1;
                    if (walk_last) begin
                        walk_idx <= '0;
                        if (cmd_if.init_done) begin
                            state <= S_ACK;
                        end else begin
                            cmd_if.init_done <= 1'b1;
                            state            <= S_IDLE;
                        end
                    end
                end
                S_IDLE : begin
                    if (accept && (cmd_if.command == CMD_CLEAR)) begin
                        state       <= S_WALK;
                        cmd_if.fill <= '0;
                    end else if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP : begin
                    state <= S_ACK;
                    if ((cmd_q == CMD_SET) && !hit && free) begin
                        cmd_if.fill <= cmd_if.fill + 1'b1;
                    end else if ((cmd_q == CMD_UNSET) && hit) begin
                        cmd_if.fill <= cmd_if.fill - 1'b1;
                    end
                end
                default : state <= S_IDLE;
            endcase
        end
    end

    // Request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q   <= cmd_if.command;
            key_q   <= cmd_if.key;
            value_q <= cmd_if.set_value;
        end
    end

    // Results hold the key's previous contents, ready by the ack cycle
    always_ff @(posedge clk) begin
        if (state == S_LOOKUP) begin
            cmd_if.get_valid <= hit;
            cmd_if.get_value <= hit ? values[hit_idx] : '0;
            cmd_if.status    <= ((cmd_q == CMD_SET) && !hit && !free) ? DB_ERROR : DB_OK;
        end else if (state == S_WALK) begin
            cmd_if.get_valid <= 1'b0;
            cmd_if.get_value <= '0;
            cmd_if.status    <= DB_OK;
        end
    end

endmodule

// File: logic/kvdb_top.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

module kvdb_top (
    input  logic                      clk,
    input  logic                      srst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`KVDB_ADR_BITS-1:0] wb_adr,
    input  logic [31:0]               wb_dat_w,
    output logic [31:0]               wb_dat_r,
    output logic                      wb_ack
);
    import kvdb_pkg::*;

    kvdb_reg_if reg_if ();
    kvdb_cmd_if cmd_if ();

    // ------------------------------
    // Register block
    // ------------------------------
    kvdb_wb_regs u_regs (
        .clk    ( clk ),
        .srst   ( srst ),
        .cyc    ( wb_cyc ),
        .stb    ( wb_stb ),
        .we     ( wb_we ),
        .adr    ( reg_addr_t'(wb_adr) ),
        .dat_w  ( wb_dat_w ),
        .dat_r  ( wb_dat_r ),
        .ack    ( wb_ack ),
        .reg_if ( reg_if.regs )
    );

    // Sequencer
    kvdb_ctrl u_ctrl (
        .clk    ( clk ),
        .srst   ( srst ),
        .reg_if ( reg_if.ctrl ),
        .cmd_if ( cmd_if.ctrl )
    );

    // Storage
    kvdb_stash u_stash (
        .clk    ( clk ),
        .srst   ( srst ),
        .cmd_if ( cmd_if.stash )
    );

endmodule

// File: logic/kvdb_wb_regs.sv
`timescale 1ns/1ns
`include "kvdb_settings.svh"

module kvdb_wb_regs (
    input  logic                clk,
    input  logic                srst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  kvdb_pkg::reg_addr_t adr,
    input  logic [31:0]         dat_w,
    output logic [31:0]         dat_r,
    output logic                ack,
    kvdb_reg_if.regs            reg_if
);
    import kvdb_pkg::*;

    localparam int KEY_BITS   = `KVDB_KEY_BITS;
    localparam int VALUE_BITS = `KVDB_VALUE_BITS;
    localparam int DEPTH      = `KVDB_DEPTH;
    localparam int FILL_BITS  = `KVDB_FILL_BITS;

    logic        wr_acc;
    logic        rd_acc;
    logic [31:0] info_word;
    logic [31:0] status_word;

    // ------------------------------
    // Bus handshake
    // ------------------------------
    // One ack per access, never back to back
    always_ff @(posedge clk) begin
        if (srst) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc && stb && !ack;
        end
    end

    // Master holds its signals through the ack cycle
    assign wr_acc = ack && we;
    assign rd_acc = ack && !we;

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            reg_if.key       <= '0;
            reg_if.set_value <= '0;
        end else if (wr_acc) begin
            if (adr == REG_KEY) begin
                reg_if.key <= dat_w[KEY_BITS-1:0];
            end
            if (adr == REG_SET_VALUE) begin
                reg_if.set_value <= dat_w[VALUE_BITS-1:0];
            end
        end
    end

    // Event pulses toward the sequencer
    assign reg_if.cmd_wr    = wr_acc && (adr == REG_COMMAND);
    assign reg_if.cmd_code  = command_t'(dat_w[2:0]);
    assign reg_if.status_rd = rd_acc && (adr == REG_STATUS);

    // ------------------------------
    // Read words
    // ------------------------------
    assign info_word = {8'd0, 8'(DEPTH), 8'(VALUE_BITS), 8'(KEY_BITS)};

    always_comb begin
        status_word                 = '0;
        status_word[1:0]            = reg_if.status_code;
        status_word[4]              = reg_if.done;
        status_word[5]              = reg_if.error;
        status_word[8 +: FILL_BITS] = reg_if.fill;
    end

    // Flags clear after this cycle, so the read sees them before the clear
    always_comb begin
        case (adr)
            REG_INFO      : dat_r = info_word;
            REG_KEY       : dat_r = 32'(reg_if.key);
            REG_SET_VALUE : dat_r = 32'(reg_if.set_value);
            REG_STATUS    : dat_r = status_word;
            REG_GET_VALUE : dat_r = 32'(reg_if.get_value);
            REG_GET_VALID : dat_r = 32'(reg_if.get_valid);
            default       : dat_r = '0;
        endcase
    end

endmodule

// File: tb.f
+incdir+logic
logic/kvdb_pkg.sv
logic/kvdb_reg_if.sv
logic/kvdb_cmd_if.sv
logic/kvdb_wb_regs.sv
logic/kvdb_ctrl.sv
logic/kvdb_stash.sv
logic/kvdb_top.sv
bench/kvdb_asserts.sv
bench/kvdb_tb.sv
